//--- include/wfg_defines.svh
/* Bus map, register offsets and field widths of the waveform generator.
   Include wherever an address, an offset or a width is needed. */
`ifndef WFG_DEFINES_SVH
`define WFG_DEFINES_SVH

// Wishbone data and address width
`define WFG_BUS_W 32

// Low address bits that select a register inside a page
`define WFG_OFS_W 4

// Page numbers, compared against address bits 31 to 4
`define WFG_CORE_PAGE 28'h000_0001
`define WFG_SINE_PAGE 28'h000_0002
`define WFG_SPI_PAGE  28'h000_0003

// Register offsets inside a page
`define WFG_REG_CTRL 4'h0
`define WFG_REG_CFG  4'h4
`define WFG_REG_AUX  4'h8

// Sample stream
`define WFG_SAMPLE_W 16

// Fraction bits of the oscillator coefficient, Q1.14
`define WFG_COEF_FRAC 14

// Core timer fields, subcycle divider and sync count
`define WFG_CORE_DIV_W 8

// SPI clock divider field
`define WFG_SPI_DIV_W 8

`endif

//--- rtl/wfg_pkg.sv
/* Types shared by the sine stimulus, the SPI drive and the testbench.
   Import with a wildcard in the module header. */
`default_nettype none

`include "wfg_defines.svh"

package wfg_pkg;

    // One signed sample on the sine to SPI stream
    typedef logic signed [`WFG_SAMPLE_W-1:0] sample_t;

    // SPI frame states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        SHIFT = 2'd1,
        DONE  = 2'd2
    } spi_state_e;

endpackage

`default_nettype wire

//--- rtl/wfg_core.sv
/* Core timer on page 0x10. CFG[7:0] sets the subcycle divider and
   CFG[15:8] the number of subcycles per sync pulse. */
`timescale 1ns/1ps
`default_nettype none

`include "wfg_defines.svh"

module wfg_core (
    input  logic                  io_wbs_clk,
    input  logic                  arst_n_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  logic [`WFG_OFS_W-1:0] adr_i,
    input  logic [`WFG_BUS_W-1:0] dat_i,
    output logic                  ack_o,
    output logic [`WFG_BUS_W-1:0] dat_o,
    output logic                  subcycle_o,
    output logic                  sync_o,
    output logic                  active_o
);

    logic                          hold_q;
    logic                          acc;
    logic                          wr;
    logic [`WFG_BUS_W-1:0]         rd_data;
    logic                          ctrl_en_q;
    logic [2*`WFG_CORE_DIV_W-1:0]  cfg_q;
    logic [`WFG_CORE_DIV_W-1:0]    sub_cnt_q;
    logic [`WFG_CORE_DIV_W-1:0]    sync_cnt_q;

    // Accept a strobe once, then wait for it to drop
    assign acc = stb_i && !hold_q;
    assign wr  = acc && we_i;

    always_comb begin
        rd_data = '0;
        case (adr_i)
            `WFG_REG_CTRL: rd_data[0] = ctrl_en_q;
            `WFG_REG_CFG:  rd_data[2*`WFG_CORE_DIV_W-1:0] = cfg_q;
            default:       rd_data = '0;
        endcase
    end

    always_ff @(posedge io_wbs_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hold_q    <= 1'b0;
            ack_o     <= 1'b0;
            dat_o     <= '0;
            ctrl_en_q <= 1'b0;
            cfg_q     <= '0;
        end else begin
            hold_q <= stb_i;
            ack_o  <= acc;
            if (acc) begin
                dat_o <= rd_data;
            end
            if (wr && adr_i == `WFG_REG_CTRL) begin
                ctrl_en_q <= dat_i[0];
            end
            if (wr && adr_i == `WFG_REG_CFG) begin
                cfg_q <= dat_i[2*`WFG_CORE_DIV_W-1:0];
            end
        end
    end

    // Subcycle and sync counters, restarted by any CTRL write
    always_ff @(posedge io_wbs_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sub_cnt_q  <= '0;
            sync_cnt_q <= '0;
            subcycle_o <= 1'b0;
            sync_o     <= 1'b0;
        end else if ((wr && adr_i == `WFG_REG_CTRL) || !ctrl_en_q) begin
            sub_cnt_q  <= '0;
            sync_cnt_q <= '0;
            subcycle_o <= 1'b0;
            sync_o     <= 1'b0;
        end else begin
            subcycle_o <= 1'b0;
            sync_o     <= 1'b0;
            if (sub_cnt_q == cfg_q[`WFG_CORE_DIV_W-1:0]) begin
                sub_cnt_q  <= '0;
                subcycle_o <= 1'b1;
                if (sync_cnt_q == cfg_q[2*`WFG_CORE_DIV_W-1:`WFG_CORE_DIV_W]) begin
                    sync_cnt_q <= '0;
                    sync_o     <= 1'b1;
                end else begin
                    sync_cnt_q <= sync_cnt_q + 1'b1;
                end
            end else begin
                sub_cnt_q <= sub_cnt_q + 1'b1;
            end
        end
    end

    assign active_o = ctrl_en_q;

endmodule

`default_nettype wire

//--- rtl/wfg_stim_sine.sv
/* Sine stimulus on page 0x20, a second order recursive oscillator.
   CFG holds COEF in bits 15:0 and INIT in bits 31:16, AUX reads the sample. */
`timescale 1ns/1ps
`default_nettype none

`include "wfg_defines.svh"

module wfg_stim_sine
    import wfg_pkg::*;
(
    input  logic                  io_wbs_clk,
    input  logic                  arst_n_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  logic [`WFG_OFS_W-1:0] adr_i,
    input  logic [`WFG_BUS_W-1:0] dat_i,
    input  logic                  sample_ready_i,
    output logic                  ack_o,
    output logic [`WFG_BUS_W-1:0] dat_o,
    output logic                  sample_valid_o,
    output sample_t               sample_o
);

    logic                            hold_q;
    logic                            acc;
    logic                            wr;
    logic [`WFG_BUS_W-1:0]           rd_data;
    logic                            ctrl_en_q;
    sample_t                         coef_q;
    sample_t                         init_q;
    sample_t                         s_cur_q;
    sample_t                         s_prev_q;
    logic signed [2*`WFG_SAMPLE_W-1:0] prod;
    logic signed [2*`WFG_SAMPLE_W-1:0] prod_sh;
    sample_t                         next_sample;

    assign acc = stb_i && !hold_q;
    assign wr  = acc && we_i;

    always_comb begin
        rd_data = '0;
        case (adr_i)
            `WFG_REG_CTRL: rd_data[0] = ctrl_en_q;
            `WFG_REG_CFG:  rd_data = {init_q, coef_q};
            `WFG_REG_AUX:  rd_data[`WFG_SAMPLE_W-1:0] = s_cur_q;
            default:       rd_data = '0;
        endcase
    end

    always_ff @(posedge io_wbs_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hold_q    <= 1'b0;
            ack_o     <= 1'b0;
            dat_o     <= '0;
            ctrl_en_q <= 1'b0;
            coef_q    <= '0;
            init_q    <= '0;
        end else begin
            hold_q <= stb_i;
            ack_o  <= acc;
            if (acc) begin
                dat_o <= rd_data;
            end
            if (wr && adr_i == `WFG_REG_CTRL) begin
                ctrl_en_q <= dat_i[0];
            end
            if (wr && adr_i == `WFG_REG_CFG) begin
                coef_q <= dat_i[`WFG_SAMPLE_W-1:0];
                init_q <= dat_i[2*`WFG_SAMPLE_W-1:`WFG_SAMPLE_W];
            end
        end
    end

    // s[n+1] = (s[n] * coef) >>> 14 - s[n-1], wrapping to 16 bits
    assign prod        = s_cur_q * coef_q;
    assign prod_sh     = prod >>> `WFG_COEF_FRAC;
    assign next_sample = sample_t'(prod_sh[`WFG_SAMPLE_W-1:0]) - s_prev_q;

    // Seeding s[-1] with -INIT makes the first step produce INIT
    always_ff @(posedge io_wbs_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s_cur_q  <= '0;
            s_prev_q <= '0;
        end else if (wr && adr_i == `WFG_REG_CTRL && dat_i[0]) begin
            s_cur_q  <= '0;
            s_prev_q <= -init_q;
        end else if (sample_valid_o && sample_ready_i) begin
            s_prev_q <= s_cur_q;
            s_cur_q  <= next_sample;
        end
    end

    assign sample_valid_o = ctrl_en_q;
    assign sample_o       = s_cur_q;

endmodule

`default_nettype wire

//--- rtl/wfg_drive_spi.sv
/* SPI drive on page 0x30, sends one 16-bit sample MSB first per sync pulse.
   CFG[7:0] sets the half period of sclk in clocks minus one. */
`timescale 1ns/1ps
`default_nettype none

`include "wfg_defines.svh"

module wfg_drive_spi
    import wfg_pkg::*;
(
    input  logic                  io_wbs_clk,
    input  logic                  arst_n_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  logic [`WFG_OFS_W-1:0] adr_i,
    input  logic [`WFG_BUS_W-1:0] dat_i,
    input  logic                  sync_i,
    input  logic                  sample_valid_i,
    input  sample_t               sample_i,
    output logic                  ack_o,
    output logic [`WFG_BUS_W-1:0] dat_o,
    output logic                  sample_ready_o,
    output logic                  sclk_o,
    output logic                  cs_no,
    output logic                  sdo_o,
    output logic                  sdo_en_o
);

    // 16 rising plus 16 falling sclk edges per frame
    localparam int EDGE_W = $clog2(2 * `WFG_SAMPLE_W);
    localparam logic [EDGE_W-1:0] LAST_EDGE = EDGE_W'(2 * `WFG_SAMPLE_W - 1);

    logic                      hold_q;
    logic                      acc;
    logic                      wr;
    logic [`WFG_BUS_W-1:0]     rd_data;
    logic                      ctrl_en_q;
    logic [`WFG_SPI_DIV_W-1:0] cfg_q;
    sample_t                   last_q;
    spi_state_e                state_q;
    logic [`WFG_SPI_DIV_W-1:0] div_q;
    logic [EDGE_W-1:0]         edge_q;
    logic [`WFG_SAMPLE_W-1:0]  shift_q;
    logic                      start;

    assign acc = stb_i && !hold_q;
    assign wr  = acc && we_i;

    always_comb begin
        rd_data = '0;
        case (adr_i)
            `WFG_REG_CTRL: rd_data[0] = ctrl_en_q;
            `WFG_REG_CFG:  rd_data[`WFG_SPI_DIV_W-1:0] = cfg_q;
            `WFG_REG_AUX:  rd_data[`WFG_SAMPLE_W-1:0] = last_q;
            default:       rd_data = '0;
        endcase
    end

    always_ff @(posedge io_wbs_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hold_q    <= 1'b0;
            ack_o     <= 1'b0;
            dat_o     <= '0;
            ctrl_en_q <= 1'b0;
            cfg_q     <= '0;
        end else begin
            hold_q <= stb_i;
            ack_o  <= acc;
            if (acc) begin
                dat_o <= rd_data;
            end
            if (wr && adr_i == `WFG_REG_CTRL) begin
                ctrl_en_q <= dat_i[0];
            end
            if (wr && adr_i == `WFG_REG_CFG) begin
                cfg_q <= dat_i[`WFG_SPI_DIV_W-1:0];
            end
        end
    end

    // Take a sample only on sync while idle, later syncs are dropped
    assign start          = (state_q == IDLE) && ctrl_en_q && sync_i && sample_valid_i;
    assign sample_ready_o = start;

    always_ff @(posedge io_wbs_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= IDLE;
            div_q    <= '0;
            edge_q   <= '0;
            shift_q  <= '0;
            last_q   <= '0;
            sclk_o   <= 1'b0;
            cs_no    <= 1'b1;
            sdo_en_o <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start) begin
                        shift_q  <= sample_i;
                        last_q   <= sample_i;
                        div_q    <= '0;
                        edge_q   <= '0;
                        cs_no    <= 1'b0;
                        sdo_en_o <= 1'b1;
                        state_q  <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (div_q == cfg_q) begin
                        div_q  <= '0;
                        sclk_o <= !sclk_o;
                        edge_q <= edge_q + 1'b1;
                        // Next bit goes out after each falling edge
                        if (sclk_o) begin
                            shift_q <= {shift_q[`WFG_SAMPLE_W-2:0], 1'b0};
                            if (edge_q == LAST_EDGE) begin
                                state_q <= DONE;
                            end
                        end
                    end else begin
                        div_q <= div_q + 1'b1;
                    end
                end
                DONE: begin
                    cs_no    <= 1'b1;
                    sdo_en_o <= 1'b0;
                    state_q  <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    assign sdo_o = shift_q[`WFG_SAMPLE_W-1];

endmodule

`default_nettype wire

//--- rtl/wfg_top.sv
/* Waveform generator top, Wishbone slave with core timer, sine stimulus
   and SPI drive on pages 0x10, 0x20 and 0x30. */
`timescale 1ns/1ps
`default_nettype none

`include "wfg_defines.svh"

module wfg_top
    import wfg_pkg::*;
(
    input  logic                  io_wbs_clk,
    input  logic                  arst_n_i,
    input  logic [`WFG_BUS_W-1:0] io_wbs_adr_i,
    input  logic [`WFG_BUS_W-1:0] io_wbs_datwr_i,
    input  logic                  io_wbs_we_i,
    input  logic                  io_wbs_stb_i,
    input  logic                  io_wbs_cyc_i,
    output logic [`WFG_BUS_W-1:0] io_wbs_datrd_o,
    output logic                  io_wbs_ack_o,
    output logic                  io_wbs_err_o,
    output logic                  wfg_drive_spi_sclk_o,
    output logic                  wfg_drive_spi_cs_no,
    output logic                  wfg_drive_spi_sdo_o,
    output logic                  wfg_drive_spi_sdo_en_o
);

    logic                  bus_stb;
    logic                  core_sel;
    logic                  sine_sel;
    logic                  spi_sel;
    logic                  none_sel;
    logic                  err_hold_q;

    logic                  core_ack;
    logic                  sine_ack;
    logic                  spi_ack;
    logic [`WFG_BUS_W-1:0] core_dat;
    logic [`WFG_BUS_W-1:0] sine_dat;
    logic [`WFG_BUS_W-1:0] spi_dat;

    logic                  core_sync;
    logic                  sample_valid;
    logic                  sample_ready;
    sample_t               sample;

    assign bus_stb = io_wbs_stb_i && io_wbs_cyc_i;

    // Page decode on address bits 31 to 4
    assign core_sel = (io_wbs_adr_i[`WFG_BUS_W-1:`WFG_OFS_W] == `WFG_CORE_PAGE);
    assign sine_sel = (io_wbs_adr_i[`WFG_BUS_W-1:`WFG_OFS_W] == `WFG_SINE_PAGE);
    assign spi_sel  = (io_wbs_adr_i[`WFG_BUS_W-1:`WFG_OFS_W] == `WFG_SPI_PAGE);
    assign none_sel = !core_sel && !sine_sel && !spi_sel;

    // One error pulse per unmapped access, the strobe stays high until then
    always_ff @(posedge io_wbs_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_hold_q   <= 1'b0;
            io_wbs_err_o <= 1'b0;
        end else begin
            err_hold_q   <= bus_stb && none_sel;
            io_wbs_err_o <= bus_stb && none_sel && !err_hold_q;
        end
    end

    // Merge the block answers, data is zero when nobody acks
    always_ff @(posedge io_wbs_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            io_wbs_ack_o   <= 1'b0;
            io_wbs_datrd_o <= '0;
        end else begin
            io_wbs_ack_o <= core_ack || sine_ack || spi_ack;
            if (core_ack) begin
                io_wbs_datrd_o <= core_dat;
            end else if (sine_ack) begin
                io_wbs_datrd_o <= sine_dat;
            end else if (spi_ack) begin
                io_wbs_datrd_o <= spi_dat;
            end else begin
                io_wbs_datrd_o <= '0;
            end
        end
    end

    // Subcycle and active state have no user at this level
    wfg_core wfg_core_inst (
        .io_wbs_clk (io_wbs_clk),
        .arst_n_i   (arst_n_i),
        .stb_i      (bus_stb && core_sel),
        .we_i       (io_wbs_we_i),
        .adr_i      (io_wbs_adr_i[`WFG_OFS_W-1:0]),
        .dat_i      (io_wbs_datwr_i),
        .ack_o      (core_ack),
        .dat_o      (core_dat),
        .subcycle_o (),
        .sync_o     (core_sync),
        .active_o   ()
    );

    wfg_stim_sine wfg_stim_sine_inst (
        .io_wbs_clk     (io_wbs_clk),
        .arst_n_i       (arst_n_i),
        .stb_i          (bus_stb && sine_sel),
        .we_i           (io_wbs_we_i),
        .adr_i          (io_wbs_adr_i[`WFG_OFS_W-1:0]),
        .dat_i          (io_wbs_datwr_i),
        .sample_ready_i (sample_ready),
        .ack_o          (sine_ack),
        .dat_o          (sine_dat),
        .sample_valid_o (sample_valid),
        .sample_o       (sample)
    );

    wfg_drive_spi wfg_drive_spi_inst (
        .io_wbs_clk     (io_wbs_clk),
        .arst_n_i       (arst_n_i),
        .stb_i          (bus_stb && spi_sel),
        .we_i           (io_wbs_we_i),
        .adr_i          (io_wbs_adr_i[`WFG_OFS_W-1:0]),
        .dat_i          (io_wbs_datwr_i),
        .sync_i         (core_sync),
        .sample_valid_i (sample_valid),
        .sample_i       (sample),
        .ack_o          (spi_ack),
        .dat_o          (spi_dat),
        .sample_ready_o (sample_ready),
        .sclk_o         (wfg_drive_spi_sclk_o),
        .cs_no          (wfg_drive_spi_cs_no),
        .sdo_o          (wfg_drive_spi_sdo_o),
        .sdo_en_o       (wfg_drive_spi_sdo_en_o)
    );

endmodule

`default_nettype wire

//--- tb/wfg_tb.sv
/* Testbench for the waveform generator top. Drives Wishbone accesses,
   decodes the SPI frames and checks them against a reference oscillator. */
`timescale 1ns/1ps
`default_nettype none

`include "wfg_defines.svh"

module wfg_tb
    import wfg_pkg::*;
();

    localparam int bus_limit  = 20;
    localparam int wait_limit = 50000;

    logic        clk;
    logic        arst_n;
    logic [31:0] adr;
    logic [31:0] datwr;
    logic        we;
    logic        stb;
    logic        cyc;
    logic [31:0] datrd;
    logic        ack;
    logic        err;
    logic        sclk;
    logic        cs_n;
    logic        sdo;
    logic        sdo_en;
    spi_state_e  spi_state;

    // Monitor side
    int unsigned cycle_cnt = 0;
    bit          mon_on    = 1'b0;
    logic        prev_cs   = 1'b1;
    logic        prev_sclk = 1'b0;
    logic [15:0] rx_word   = '0;
    int          rise_cnt  = 0;
    logic [15:0] word_q[$];
    int unsigned fall_q[$];

    // word_cnt counts every word checked so far
    int          word_cnt  = 0;
    int          seq_base  = 0;
    logic [15:0] coef_g    = '0;
    logic [15:0] init_g    = '0;
    logic [15:0] got_word;
    logic [15:0] exp_word;

    wfg_top wfg_top_inst (
        .io_wbs_clk             (clk),
        .arst_n_i               (arst_n),
        .io_wbs_adr_i           (adr),
        .io_wbs_datwr_i         (datwr),
        .io_wbs_we_i            (we),
        .io_wbs_stb_i           (stb),
        .io_wbs_cyc_i           (cyc),
        .io_wbs_datrd_o         (datrd),
        .io_wbs_ack_o           (ack),
        .io_wbs_err_o           (err),
        .wfg_drive_spi_sclk_o   (sclk),
        .wfg_drive_spi_cs_no    (cs_n),
        .wfg_drive_spi_sdo_o    (sdo),
        .wfg_drive_spi_sdo_en_o (sdo_en)
    );

    assign spi_state = wfg_top_inst.wfg_drive_spi_inst.state_q;

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("Fail at %0t ns: %s is 0x%0h, expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    // s0 = 0, s1 = INIT, s[n+1] = ((s[n] * COEF) >>> 14) - s[n-1] in 16 bits
    function automatic logic [15:0] ref_sample(input logic [15:0] coef,
                                               input logic [15:0] init, input int n);
        logic signed [15:0] older;
        logic signed [15:0] cur;
        logic signed [15:0] c;
        logic signed [31:0] p;
        logic signed [31:0] sh;
        int                 k;
        older = '0;
        cur   = init;
        c     = coef;
        if (n == 0) begin
            return 16'h0000;
        end
        for (k = 1; k < n; k++) begin
            p     = 32'(cur) * 32'(c);
            sh    = p >>> `WFG_COEF_FRAC;
            p     = 32'(sh[15:0] - older);
            older = cur;
            cur   = p[15:0];
        end
        return cur;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [27:0] page, input logic [3:0] ofs);
        return {page, ofs};
    endfunction

    task automatic bus_access(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int cycles, output logic was_err);
        int   n;
        logic done;
        n       = 0;
        done    = 1'b0;
        was_err = 1'b0;
        rdata   = '0;
        @(posedge clk);
        adr   <= addr;
        datwr <= wdata;
        we    <= write;
        stb   <= 1'b1;
        cyc   <= 1'b1;
        // n counts the clocks since the strobe cycle
        while (!done) begin
            @(negedge clk);
            if (ack) begin
                rdata = datrd;
                done  = 1'b1;
            end else if (err) begin
                was_err = 1'b1;
                done    = 1'b1;
            end else begin
                n++;
                if (n > bus_limit) begin
                    fail_stop($sformatf("Bus access to 0x%08h got neither ack nor error",
                                        addr));
                end
            end
        end
        cycles = n;
        @(posedge clk);
        stb <= 1'b0;
        cyc <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        int          n;
        logic        was_err;
        bus_access(1'b1, addr, wdata, rdata, n, was_err);
        check_value("io_wbs_err_o", 32'(was_err), 32'd0);
        check_value("io_wbs_ack_o latency", 32'(n), 32'd2);
    endtask

    task automatic read_check(input logic [31:0] addr, input logic [31:0] exp);
        logic [31:0] rdata;
        int          n;
        logic        was_err;
        bus_access(1'b0, addr, 32'd0, rdata, n, was_err);
        check_value("io_wbs_err_o", 32'(was_err), 32'd0);
        check_value("io_wbs_ack_o latency", 32'(n), 32'd2);
        check_value($sformatf("io_wbs_datrd_o at 0x%02h", addr), rdata, exp);
    endtask

    task automatic write_read_check(input logic [31:0] addr, input logic [31:0] wdata,
                                    input logic [31:0] mask);
        bus_write(addr, wdata);
        read_check(addr, wdata & mask);
    endtask

    task automatic check_unmapped(input logic [31:0] addr, input logic write);
        logic [31:0] rdata;
        int          n;
        logic        was_err;
        int          i;
        bus_access(write, addr, $urandom(), rdata, n, was_err);
        check_value("io_wbs_err_o", 32'(was_err), 32'd1);
        check_value("io_wbs_err_o latency", 32'(n), 32'd1);
        // Neither a second error nor a late ack may follow
        for (i = 0; i < 6; i++) begin
            @(negedge clk);
            check_value("io_wbs_err_o", 32'(err), 32'd0);
            check_value("io_wbs_ack_o", 32'(ack), 32'd0);
        end
    endtask

    task automatic wait_words(input int n);
        int t;
        t = 0;
        while ((word_cnt - seq_base) < n) begin
            @(negedge clk);
            t++;
            if (t > wait_limit) begin
                fail_stop($sformatf("Only %0d of %0d SPI words arrived, SPI state %s",
                                    word_cnt - seq_base, n, spi_state.name()));
            end
        end
    endtask

    // Chip select has to stay high for the whole span
    task automatic stop_spi(input int span);
        int quiet;
        int t;
        quiet = 0;
        t     = 0;
        bus_write(reg_addr(`WFG_SPI_PAGE, `WFG_REG_CTRL), 32'd0);
        while (quiet < span) begin
            @(negedge clk);
            t++;
            if (cs_n) begin
                quiet++;
            end else begin
                quiet = 0;
            end
            if (t > wait_limit) begin
                fail_stop("SPI chip select kept toggling after the drive was disabled");
            end
        end
    endtask

    // Reload the sine and expect the sequence from s0 again
    task automatic restart_sine();
        seq_base = word_cnt;
        bus_write(reg_addr(`WFG_SINE_PAGE, `WFG_REG_CTRL), 32'd1);
        bus_write(reg_addr(`WFG_SPI_PAGE, `WFG_REG_CTRL), 32'd1);
    endtask

    task automatic start_stream(input int d, input int s, input int k);
        logic [31:0] rv;
        rv     = $urandom();
        coef_g = rv[15:0];
        init_g = rv[31:16];
        bus_write(reg_addr(`WFG_CORE_PAGE, `WFG_REG_CFG), {16'h0, 8'(s), 8'(d)});
        bus_write(reg_addr(`WFG_SPI_PAGE, `WFG_REG_CFG), 32'(k));
        bus_write(reg_addr(`WFG_SINE_PAGE, `WFG_REG_CFG), rv);
        restart_sine();
        bus_write(reg_addr(`WFG_CORE_PAGE, `WFG_REG_CTRL), 32'd1);
    endtask

    // SPI frame decoder
    always @(negedge clk) begin
        if (mon_on) begin
            check_value("wfg_drive_spi_sdo_en_o", 32'(sdo_en), 32'(!cs_n));
            if (prev_cs && !cs_n) begin
                fall_q.push_back(cycle_cnt);
                rx_word  = '0;
                rise_cnt = 0;
            end
            if (!cs_n && !prev_sclk && sclk) begin
                rx_word = {rx_word[14:0], sdo};
                rise_cnt++;
            end
            if (!prev_cs && cs_n) begin
                check_value("wfg_drive_spi_sclk_o rising edges", 32'(rise_cnt), 32'd16);
                word_q.push_back(rx_word);
            end
            prev_cs   = cs_n;
            prev_sclk = sclk;
        end
    end

    always @(negedge clk) begin
        if (word_q.size() > 0) begin
            got_word = word_q.pop_front();
            exp_word = ref_sample(coef_g, init_g, word_cnt - seq_base);
            check_value($sformatf("wfg_drive_spi_sdo_o word s%0d", word_cnt - seq_base),
                        32'(got_word), 32'(exp_word));
            word_cnt++;
        end
    end

    initial begin
        logic [31:0] rv;
        int          d;
        int          s;
        int          k;
        int          period;
        int          fall_base;
        int          n_fall;
        int          i;
        void'($urandom(57));
        arst_n <= 1'b0;
        adr    <= '0;
        datwr  <= '0;
        we     <= 1'b0;
        stb    <= 1'b0;
        cyc    <= 1'b0;
        repeat (8) begin
            @(posedge clk);
        end
        arst_n <= 1'b1;
        @(posedge clk);
        mon_on = 1'b1;

        // Register fields and unused offsets
        rv = $urandom();
        write_read_check(reg_addr(`WFG_CORE_PAGE, `WFG_REG_CTRL), rv, 32'h0000_0001);
        rv = $urandom();
        write_read_check(reg_addr(`WFG_CORE_PAGE, `WFG_REG_CFG), rv, 32'h0000_ffff);
        read_check(reg_addr(`WFG_CORE_PAGE, `WFG_REG_AUX), 32'd0);
        read_check(reg_addr(`WFG_CORE_PAGE, 4'hc), 32'd0);
        rv = $urandom();
        write_read_check(reg_addr(`WFG_SINE_PAGE, `WFG_REG_CTRL), rv, 32'h0000_0001);
        rv = $urandom();
        write_read_check(reg_addr(`WFG_SINE_PAGE, `WFG_REG_CFG), rv, 32'hffff_ffff);
        read_check(reg_addr(`WFG_SINE_PAGE, `WFG_REG_AUX), 32'd0);
        read_check(reg_addr(`WFG_SINE_PAGE, 4'hc), 32'd0);
        rv = $urandom();
        write_read_check(reg_addr(`WFG_SPI_PAGE, `WFG_REG_CFG), rv, 32'h0000_00ff);
        read_check(reg_addr(`WFG_SPI_PAGE, `WFG_REG_CTRL), 32'd0);
        read_check(reg_addr(`WFG_SPI_PAGE, `WFG_REG_AUX), 32'd0);
        read_check(reg_addr(`WFG_SPI_PAGE, 4'hc), 32'd0);
        bus_write(reg_addr(`WFG_CORE_PAGE, `WFG_REG_CTRL), 32'd0);
        bus_write(reg_addr(`WFG_SINE_PAGE, `WFG_REG_CTRL), 32'd0);

        // Pages 0 and 0x40 are unmapped
        check_unmapped(32'h0000_0004, 1'b0);
        check_unmapped(32'h0000_0048, 1'b1);

        // Frame fits inside one sync period
        d         = int'($urandom_range(10, 3));
        k         = int'($urandom_range(3, 0));
        s         = (32 * (k + 1) + 8) / (d + 1) + int'($urandom_range(2, 0));
        period    = (d + 1) * (s + 1);
        fall_base = fall_q.size();
        start_stream(d, s, k);
        wait_words(20);
        n_fall = fall_q.size();
        for (i = fall_base + 1; i < n_fall; i++) begin
            check_value("wfg_drive_spi_cs_no fall interval",
                        32'(fall_q[i] - fall_q[i - 1]), 32'(period));
        end

        // Sync period shorter than a frame
        stop_spi(4 * period + 150);
        k      = int'($urandom_range(2, 1));
        period = 8;
        start_stream(1, 3, k);
        wait_words(20);

        // Drive disabled, then the sine restarts from s0
        stop_spi(4 * period + 150);
        restart_sine();
        wait_words(8);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
rtl/wfg_pkg.sv
rtl/wfg_core.sv
rtl/wfg_stim_sine.sv
rtl/wfg_drive_spi.sv
rtl/wfg_top.sv
tb/wfg_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the waveform generator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module wfg_tb -Mdir obj_dir -o wfg_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/wfg_sim 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
